// File: files.f
disp_pkg.sv
disp_if.sv
ahb_disp_regs.sv
run_painter.sv
raster_timing.sv
frame_scanout.sv
ahb_display.sv
tb_display_checker.sv
tb_display_assert.sv
tb_ahb_display.sv

// File: Bender.yml
package:
  name: ahb_display

sources:
  - files:
      - disp_pkg.sv
      - disp_if.sv
      - ahb_disp_regs.sv
      - run_painter.sv
      - raster_timing.sv
      - frame_scanout.sv
      - ahb_display.sv
  - target: test
    files:
      - tb_display_checker.sv
      - tb_display_assert.sv
      - tb_ahb_display.sv

// File: tb_ahb_display.sv
`timescale 1ns/100ps

module tb_ahb_display;
    import disp_pkg::*;

    localparam int FB_DEPTH     = H_ACTIVE_DEF * V_ACTIVE_DEF;
    localparam int FRAME_CYCLES = H_TOTAL_DEF * V_TOTAL_DEF;
    localparam int N_RANDOM     = 30;
    localparam int N_RUNS       = N_RANDOM + 2;
    localparam int MAX_LEN      = FB_DEPTH;
    localparam int CYCLE_LIMIT  = N_RUNS * (MAX_LEN + 20) + 12 * FRAME_CYCLES;

    logic        HCLK;
    logic        HRESETn;
    logic        HSEL;
    logic [31:0] HADDR;
    logic [1:0]  HTRANS;
    logic [2:0]  HSIZE;
    logic [3:0]  HPROT;
    logic        HWRITE;
    logic [31:0] HWDATA;
    logic        HREADY;
    logic        HREADYOUT;
    logic [31:0] HRDATA;
    logic        HRESP;
    pixel_t      vid_rgb;
    logic        vid_de;
    logic        vid_hsync;
    logic        vid_vsync;

    logic        rd_check;
    reg_addr_t   rd_addr;
    logic [31:0] rd_expect;
    logic        video_check;
    logic        enable_exp;
    pixel_t      fb_model [FB_DEPTH];
    int          rd_errors;
    int          vid_errors;
    int          frames_checked;
    int          other_errors = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state;

    ahb_display u_dut
    (
        .HCLK (HCLK), .HRESETn (HRESETn), .HSEL (HSEL), .HADDR (HADDR),
        .HTRANS (HTRANS), .HSIZE (HSIZE), .HPROT (HPROT), .HWRITE (HWRITE),
        .HWDATA (HWDATA), .HREADY (HREADY), .HREADYOUT (HREADYOUT),
        .HRDATA (HRDATA), .HRESP (HRESP), .vid_rgb (vid_rgb), .vid_de (vid_de),
        .vid_hsync (vid_hsync), .vid_vsync (vid_vsync)
    );

    tb_display_checker #(.H_ACTIVE(H_ACTIVE_DEF), .H_TOTAL(H_TOTAL_DEF),
                         .V_ACTIVE(V_ACTIVE_DEF), .V_TOTAL(V_TOTAL_DEF)) u_chk
    (
        .HCLK (HCLK), .HRESETn (HRESETn), .HRDATA (HRDATA), .vid_rgb (vid_rgb),
        .vid_de (vid_de), .vid_hsync (vid_hsync), .vid_vsync (vid_vsync),
        .rd_check (rd_check), .rd_addr (rd_addr), .rd_expect (rd_expect),
        .video_check (video_check), .enable_exp (enable_exp), .fb_model (fb_model),
        .rd_errors (rd_errors), .vid_errors (vid_errors),
        .frames_checked (frames_checked)
    );

    always #4 HCLK = ~HCLK;

    always @(posedge HCLK)
    begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // ****************************************
    // bus transfers, entered and left 1 ns after a rising edge.
    // ****************************************
    task automatic ahb_write(input reg_addr_t addr, input logic [31:0] data);
        HSEL   = 1'b1;
        HTRANS = 2'b10;
        HWRITE = 1'b1;
        HADDR  = {24'h0, addr};
        @(posedge HCLK);
        #1;
        HSEL   = 1'b0;
        HTRANS = 2'b00;
        HWRITE = 1'b0;
        HWDATA = data;
        @(posedge HCLK);
        #1;
    endtask

    task automatic ahb_read(input reg_addr_t addr, input logic check,
                            input logic [31:0] exp_data, output logic [31:0] data);
        HSEL   = 1'b1;
        HTRANS = 2'b10;
        HWRITE = 1'b0;
        HADDR  = {24'h0, addr};
        @(posedge HCLK);
        #1;
        HSEL      = 1'b0;
        HTRANS    = 2'b00;
        rd_check  = check;
        rd_addr   = addr;
        rd_expect = exp_data;
        #2;
        data = HRDATA;
        @(posedge HCLK);
        #1;
        rd_check = 1'b0;
    endtask

    task automatic check_read(input reg_addr_t addr, input logic [31:0] exp_data);
        logic [31:0] data;
        ahb_read(addr, 1'b1, exp_data, data);
    endtask

    task automatic write_readback(input reg_addr_t addr, input logic [31:0] mask);
        logic [31:0] v;
        v = next_random();
        ahb_write(addr, v);
        check_read(addr, v & mask);
    endtask

    // the painter walks linear addresses and drops those past the store.
    task automatic paint_model(input coord_t x, input coord_t y, input len_t len,
                               input pixel_t colour);
        int i;
        int a;
        for (i = 0; i < int'(len); i++)
        begin
            a = int'(y) * H_ACTIVE_DEF + int'(x) + i;
            if (a < FB_DEPTH)
                fb_model[a] = colour;
        end
    endtask

    task automatic do_run(input coord_t x, input coord_t y, input len_t len,
                          input pixel_t colour);
        logic [31:0] data;
        int          polls;
        ahb_write(REG_X, 32'(x));
        ahb_write(REG_Y, 32'(y));
        ahb_write(REG_PIXEL, 32'(colour));
        ahb_write(REG_LEN, 32'(len));
        ahb_write(REG_START, 32'h1);
        paint_model(x, y, len, colour);
        ahb_read(REG_BUSY, 1'b1, 32'(len != '0), data);
        polls = 0;
        while (data[0] && (polls < int'(len) + 4))
        begin
            ahb_read(REG_BUSY, 1'b0, 32'h0, data);
            polls++;
        end
        if (data[0])
        begin
            other_errors++;
            $display("busy still high %0d polls after a run of length %0d", polls, len);
        end
    endtask

    task automatic wait_frames(input int n);
        int base;
        int cnt;
        base = frames_checked;
        cnt  = 0;
        while ((frames_checked < base + n) && (cnt < (n + 2) * FRAME_CYCLES))
        begin
            @(posedge HCLK);
            #1;
            cnt++;
        end
        if (frames_checked < base + n)
        begin
            other_errors++;
            $display("only %0d of %0d video frames were checked", frames_checked - base, n);
        end
    endtask

    task automatic wait_vsync_period();
        int cnt;
        cnt = 0;
        while (!vid_vsync && (cnt < 2 * FRAME_CYCLES))
        begin
            @(posedge HCLK);
            #1;
            cnt++;
        end
        while (vid_vsync && (cnt < 2 * FRAME_CYCLES))
        begin
            @(posedge HCLK);
            #1;
            cnt++;
        end
        if (cnt >= 2 * FRAME_CYCLES)
        begin
            other_errors++;
            $display("vid_vsync did not complete a period within %0d cycles", cnt);
        end
    endtask

    initial
    begin
        int          i;
        coord_t      rx;
        coord_t      ry;
        len_t        rl;
        logic [31:0] data;
        HCLK        = 1'b0;
        HRESETn     = 1'b0;
        HSEL        = 1'b0;
        HADDR       = '0;
        HTRANS      = 2'b00;
        HSIZE       = 3'b010;
        HPROT       = 4'b0011;
        HWRITE      = 1'b0;
        HWDATA      = '0;
        HREADY      = 1'b1;
        rd_check    = 1'b0;
        rd_addr     = '0;
        rd_expect   = '0;
        video_check = 1'b0;
        enable_exp  = 1'b0;
        rng_state   = 32'd24;
        for (i = 0; i < FB_DEPTH; i++)
            fb_model[i] = '0;
        repeat (3) @(posedge HCLK);
        #1;
        HRESETn = 1'b1;
        @(posedge HCLK);
        #1;

        repeat (4)
        begin
            write_readback(REG_X, 32'h0000_FFFF);
            write_readback(REG_Y, 32'h0000_FFFF);
            write_readback(REG_PIXEL, 32'h00FF_FFFF);
            write_readback(REG_LEN, 32'h0000_FFFF);
            write_readback(REG_ENABLE, 32'h0000_0001);
        end
        check_read(REG_START, 32'h0);
        check_read(8'h20, 32'h0);
        check_read(8'h80, 32'h0);
        check_read(8'hFC, 32'h0);

        // full-frame clear, then a run that must not start.
        ahb_write(REG_ENABLE, 32'h1);
        enable_exp = 1'b1;
        do_run(coord_t'(0), coord_t'(0), len_t'(FB_DEPTH), pixel_t'(next_random()));
        do_run(coord_t'(5), coord_t'(3), len_t'(0), 24'hFF_FFFF);

        for (i = 0; i < N_RANDOM; i++)
        begin
            rx = coord_t'(next_random() % H_ACTIVE_DEF);
            ry = coord_t'(next_random() % V_ACTIVE_DEF);
            rl = len_t'(1 + next_random() % 80);
            // every fifth run starts late on the last line and runs off the store.
            if ((i % 5) == 4)
            begin
                ry = coord_t'(V_ACTIVE_DEF - 1);
                rx = coord_t'(16 + next_random() % 16);
                rl = len_t'(20 + next_random() % 60);
            end
            do_run(rx, ry, rl, pixel_t'(next_random()));
        end

        video_check = 1'b1;
        wait_frames(2);
        video_check = 1'b0;

        ahb_write(REG_ENABLE, 32'h0);
        enable_exp  = 1'b0;
        video_check = 1'b1;
        wait_frames(1);
        video_check = 1'b0;

        ahb_read(REG_FRAME, 1'b0, 32'h0, data);
        wait_vsync_period();
        check_read(REG_FRAME, 32'h1);
        check_read(REG_FRAME, 32'h0);

        repeat (2) @(posedge HCLK);
        $display("errors: read %0d, video %0d, other %0d",
                 rd_errors, vid_errors, other_errors);
        if ((rd_errors + vid_errors + other_errors) == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: tb_display_assert.sv
`timescale 1ns/100ps

module tb_display_assert
(
    input logic           HCLK,
    input logic           HRESETn,
    input logic           HREADYOUT,
    input logic           HRESP,
    input logic           vid_de,
    input logic           vid_hsync,
    input logic           vid_vsync,
    input logic           start,
    input logic           busy,
    input disp_pkg::len_t len
);
    import disp_pkg::*;

    len_t run_len;
    len_t busy_cycles;

    // length of the run that was accepted, and the cycles busy has been high.
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            run_len     <= '0;
            busy_cycles <= '0;
        end
        else
        begin
            if (start && !busy)
                run_len <= len;
            busy_cycles <= busy ? busy_cycles + len_t'(1) : '0;
        end
    end

    ready_high: assert property (@(posedge HCLK) disable iff (!HRESETn) HREADYOUT)
        else $error("HREADYOUT went low");

    resp_okay: assert property (@(posedge HCLK) disable iff (!HRESETn) !HRESP)
        else $error("HRESP is not OKAY");

    de_outside_sync: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                      !(vid_de && (vid_hsync || vid_vsync)))
        else $error("vid_de high during a sync pulse");

    busy_needs_start: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                       $rose(busy) |-> $past(start))
        else $error("busy rose without a start");

    busy_length: assert property (@(posedge HCLK) disable iff (!HRESETn)
                                  $fell(busy) |-> (busy_cycles == run_len))
        else $error("busy lasted %0d cycles for a run of %0d", busy_cycles, run_len);

endmodule

bind ahb_display tb_display_assert u_assert
(
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .HREADYOUT (HREADYOUT),
    .HRESP     (HRESP),
    .vid_de    (vid_de),
    .vid_hsync (vid_hsync),
    .vid_vsync (vid_vsync),
    .start     (u_run.start),
    .busy      (u_run.busy),
    .len       (u_run.len)
);

// File: tb_display_checker.sv
`timescale 1ns/100ps

module tb_display_checker
#(
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL  = 40,
    parameter int V_ACTIVE = 16,
    parameter int V_TOTAL  = 20
)
(
    input  logic                HCLK,
    input  logic                HRESETn,
    input  logic [31:0]         HRDATA,
    input  disp_pkg::pixel_t    vid_rgb,
    input  logic                vid_de,
    input  logic                vid_hsync,
    input  logic                vid_vsync,
    input  logic                rd_check,
    input  disp_pkg::reg_addr_t rd_addr,
    input  logic [31:0]         rd_expect,
    input  logic                video_check,
    input  logic                enable_exp,
    input  disp_pkg::pixel_t    fb_model [H_ACTIVE*V_ACTIVE],
    output int                  rd_errors,
    output int                  vid_errors,
    output int                  frames_checked
);
    import disp_pkg::*;

    localparam int FB_DEPTH = H_ACTIVE * V_ACTIVE;

    logic   armed;
    logic   de_q;
    logic   vsync_q;
    int     pix_idx;
    int     run_len;
    int     lines;
    int     hcnt;
    int     vcnt;
    logic   exp_hs;
    logic   exp_vs;
    pixel_t exp_rgb;

    // ****************************************
    // register read data.
    // ****************************************
    always @(negedge HCLK)
    begin
        if (!HRESETn)
            rd_errors = 0;
        else if (rd_check && (HRDATA !== rd_expect))
        begin
            rd_errors++;
            $display("[FAIL] %0t HRDATA[%02h] expected %08h actual %08h",
                     $time, rd_addr, rd_expect, HRDATA);
        end
    end

    // ****************************************
    // video stream.
    // ****************************************
    always @(negedge HCLK)
    begin
        if (!HRESETn)
        begin
            armed          = 1'b0;
            de_q           = 1'b0;
            vsync_q        = 1'b0;
            pix_idx        = 0;
            run_len        = 0;
            lines          = 0;
            hcnt           = 0;
            vcnt           = 0;
            vid_errors     = 0;
            frames_checked = 0;
        end
        else
        begin
            // raster position of the current output cycle.
            hcnt++;
            if (hcnt == H_TOTAL)
            begin
                hcnt = 0;
                vcnt = (vcnt + 1) % V_TOTAL;
            end
            if (armed)
            begin
                exp_hs = (hcnt >= H_ACTIVE + 2);
                exp_vs = (vcnt >= V_ACTIVE + 1);
                if (vid_hsync !== exp_hs)
                begin
                    vid_errors++;
                    $display("[FAIL] %0t vid_hsync expected %0b actual %0b",
                             $time, exp_hs, vid_hsync);
                end
                if (vid_vsync !== exp_vs)
                begin
                    vid_errors++;
                    $display("[FAIL] %0t vid_vsync expected %0b actual %0b",
                             $time, exp_vs, vid_vsync);
                end
                if (!vid_de && (vid_rgb !== '0))
                begin
                    vid_errors++;
                    $display("[FAIL] %0t vid_rgb expected %06h actual %06h",
                             $time, 24'h0, vid_rgb);
                end
            end

            // vsync falls together with the first active pixel of a frame.
            if (vsync_q && !vid_vsync)
            begin
                if (armed)
                begin
                    if (lines != V_ACTIVE)
                    begin
                        vid_errors++;
                        $display("[FAIL] %0t vid_de lines expected %0d actual %0d",
                                 $time, V_ACTIVE, lines);
                    end
                    frames_checked++;
                end
                armed   = video_check;
                pix_idx = 0;
                lines   = 0;
                hcnt    = 0;
                vcnt    = 0;
            end
            if (!video_check)
                armed = 1'b0;

            if (vid_de)
            begin
                run_len++;
                if (armed)
                begin
                    exp_rgb = (enable_exp && (pix_idx < FB_DEPTH)) ? fb_model[pix_idx] : '0;
                    if (vid_rgb !== exp_rgb)
                    begin
                        vid_errors++;
                        $display("[FAIL] %0t vid_rgb[%0d] expected %06h actual %06h",
                                 $time, pix_idx, exp_rgb, vid_rgb);
                    end
                end
                pix_idx++;
            end
            else if (de_q)
            begin
                // end of an active line.
                if (armed && (run_len != H_ACTIVE))
                begin
                    vid_errors++;
                    $display("[FAIL] %0t vid_de width expected %0d actual %0d",
                             $time, H_ACTIVE, run_len);
                end
                lines++;
                run_len = 0;
            end

            de_q    = vid_de;
            vsync_q = vid_vsync;
        end
    end

endmodule

// File: ahb_display.sv
`timescale 1ns/100ps

module ahb_display
#(
    parameter int H_ACTIVE = disp_pkg::H_ACTIVE_DEF,
    parameter int H_TOTAL  = disp_pkg::H_TOTAL_DEF,
    parameter int V_ACTIVE = disp_pkg::V_ACTIVE_DEF,
    parameter int V_TOTAL  = disp_pkg::V_TOTAL_DEF
)
(
    input  logic             HCLK,
    input  logic             HRESETn,
    input  logic             HSEL,
    input  logic [31:0]      HADDR,
    input  logic [1:0]       HTRANS,
    input  logic [2:0]       HSIZE,
    input  logic [3:0]       HPROT,
    input  logic             HWRITE,
    input  logic [31:0]      HWDATA,
    input  logic             HREADY,
    output logic             HREADYOUT,
    output logic [31:0]      HRDATA,
    output logic             HRESP,
    output disp_pkg::pixel_t vid_rgb,
    output logic             vid_de,
    output logic             vid_hsync,
    output logic             vid_vsync
);
    import disp_pkg::*;

    localparam int FB_AW = $clog2(H_ACTIVE * V_ACTIVE);

    logic             enable;
    logic             fb_we;
    logic [FB_AW-1:0] fb_addr;
    pixel_t           fb_wdata;

    run_if    u_run ();
    raster_if u_raster ();

    // HSIZE and HPROT stay unconnected, every access is a full word.
    ahb_disp_regs u_regs
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .HSEL      (HSEL),
        .HADDR     (HADDR),
        .HTRANS    (HTRANS),
        .HWRITE    (HWRITE),
        .HWDATA    (HWDATA),
        .HREADY    (HREADY),
        .HREADYOUT (HREADYOUT),
        .HRDATA    (HRDATA),
        .HRESP     (HRESP),
        .run       (u_run),
        .raster    (u_raster),
        .enable    (enable)
    );

    run_painter #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_painter
    (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .run      (u_run),
        .fb_we    (fb_we),
        .fb_addr  (fb_addr),
        .fb_wdata (fb_wdata)
    );

    raster_timing #(.H_ACTIVE(H_ACTIVE), .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE),
                    .V_TOTAL(V_TOTAL)) u_timing
    (
        .HCLK    (HCLK),
        .HRESETn (HRESETn),
        .raster  (u_raster)
    );

    frame_scanout #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) u_scanout
    (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .raster    (u_raster),
        .enable    (enable),
        .fb_we     (fb_we),
        .fb_addr   (fb_addr),
        .fb_wdata  (fb_wdata),
        .vid_rgb   (vid_rgb),
        .vid_de    (vid_de),
        .vid_hsync (vid_hsync),
        .vid_vsync (vid_vsync)
    );

endmodule

// File: frame_scanout.sv
`timescale 1ns/100ps

module frame_scanout
#(
    parameter int H_ACTIVE = 32,
    parameter int V_ACTIVE = 16
)
(
    input  logic                                  HCLK,
    input  logic                                  HRESETn,
    raster_if.scan                                raster,
    input  logic                                  enable,
    input  logic                                  fb_we,
    input  logic [$clog2(H_ACTIVE*V_ACTIVE)-1:0]  fb_addr,
    input  disp_pkg::pixel_t                      fb_wdata,
    output disp_pkg::pixel_t                      vid_rgb,
    output logic                                  vid_de,
    output logic                                  vid_hsync,
    output logic                                  vid_vsync
);
    import disp_pkg::*;

    localparam int FB_DEPTH = H_ACTIVE * V_ACTIVE;
    localparam int FB_AW    = $clog2(FB_DEPTH);

    pixel_t           fb_mem [FB_DEPTH];
    logic [FB_AW-1:0] rd_addr;

    // write port, a read of the same address this cycle still sees the old pixel.
    always_ff @(posedge HCLK)
    begin
        if (fb_we)
            fb_mem[fb_addr] <= fb_wdata;
    end

    assign rd_addr = FB_AW'(32'(raster.vpos) * 32'(H_ACTIVE) + 32'(raster.hpos));

    // pixel and syncs leave on the same edge.
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            vid_rgb   <= '0;
            vid_de    <= 1'b0;
            vid_hsync <= 1'b0;
            vid_vsync <= 1'b0;
        end
        else
        begin
            vid_rgb   <= (raster.de && enable) ? fb_mem[rd_addr] : '0;
            vid_de    <= raster.de;
            vid_hsync <= raster.hsync;
            vid_vsync <= raster.vsync;
        end
    end

endmodule

// File: raster_timing.sv
`timescale 1ns/100ps

module raster_timing
#(
    parameter int H_ACTIVE = 32,
    parameter int H_TOTAL  = 40,
    parameter int V_ACTIVE = 16,
    parameter int V_TOTAL  = 20
)
(
    input  logic  HCLK,
    input  logic  HRESETn,
    raster_if.gen raster
);
    import disp_pkg::*;

    localparam coord_t H_LAST    = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST    = coord_t'(V_TOTAL - 1);
    localparam coord_t H_ACT     = coord_t'(H_ACTIVE);
    localparam coord_t V_ACT     = coord_t'(V_ACTIVE);
    localparam coord_t HS_BEGIN  = coord_t'(H_ACTIVE + 2);
    localparam coord_t VS_BEGIN  = coord_t'(V_ACTIVE + 1);

    coord_t hcnt;
    coord_t vcnt;

    // ****************************************
    // position counters.
    // ****************************************
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            hcnt <= '0;
            vcnt <= '0;
        end
        else if (hcnt == H_LAST)
        begin
            hcnt <= '0;
            if (vcnt == V_LAST)
                vcnt <= '0;
            else
                vcnt <= vcnt + coord_t'(1);
        end
        else
        begin
            hcnt <= hcnt + coord_t'(1);
        end
    end

    // ****************************************
    // decoded timing.
    // ****************************************
    assign raster.hpos        = hcnt;
    assign raster.vpos        = vcnt;
    assign raster.de          = (hcnt < H_ACT) && (vcnt < V_ACT);
    assign raster.hsync       = (hcnt >= HS_BEGIN);
    assign raster.vsync       = (vcnt >= VS_BEGIN);
    assign raster.frame_start = (hcnt == '0) && (vcnt == '0);

endmodule

// File: run_painter.sv
`timescale 1ns/100ps

module run_painter
#(
    parameter int H_ACTIVE = 32,
    parameter int V_ACTIVE = 16
)
(
    input  logic                                  HCLK,
    input  logic                                  HRESETn,
    run_if.paint                                  run,
    output logic                                  fb_we,
    output logic [$clog2(H_ACTIVE*V_ACTIVE)-1:0]  fb_addr,
    output disp_pkg::pixel_t                      fb_wdata
);
    import disp_pkg::*;

    localparam int FB_DEPTH = H_ACTIVE * V_ACTIVE;
    localparam int FB_AW    = $clog2(FB_DEPTH);

    typedef enum logic {IDLE, PAINT} state_t;

    state_t      state;
    len_t        remain;
    logic [31:0] cur_addr;
    logic [31:0] start_addr;
    pixel_t      colour_q;

    // linear start position, a run simply carries on into the next line.
    assign start_addr = 32'(run.y) * 32'(H_ACTIVE) + 32'(run.x);

    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            state    <= IDLE;
            remain   <= '0;
            cur_addr <= '0;
        end
        else
        begin
            case (state)
                IDLE :
                    if (run.start && (run.len != '0))
                    begin
                        state    <= PAINT;
                        remain   <= run.len;
                        cur_addr <= start_addr;
                    end
                PAINT :
                begin
                    cur_addr <= cur_addr + 32'd1;
                    remain   <= remain - len_t'(1);
                    if (remain == len_t'(1))
                        state <= IDLE;
                end
                default : state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge HCLK)
    begin
        if ((state == IDLE) && run.start)
            colour_q <= run.colour;
    end

    assign run.busy = (state == PAINT);

    // past the end of the store the run keeps counting but stops writing.
    assign fb_we    = (state == PAINT) && (cur_addr < 32'(FB_DEPTH));
    assign fb_addr  = cur_addr[FB_AW-1:0];
    assign fb_wdata = colour_q;

endmodule

// File: ahb_disp_regs.sv
`timescale 1ns/100ps

module ahb_disp_regs
(
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL,
    input  logic [31:0] HADDR,
    input  logic [1:0]  HTRANS,
    input  logic        HWRITE,
    input  logic [31:0] HWDATA,
    input  logic        HREADY,
    output logic        HREADYOUT,
    output logic [31:0] HRDATA,
    output logic        HRESP,
    run_if.ctrl         run,
    raster_if.mon       raster,
    output logic        enable
);
    import disp_pkg::*;

    logic      addr_valid;
    logic      wr_pend;
    logic      rd_pend;
    logic      wr_done;
    logic      rd_done;
    reg_addr_t addr_q;

    coord_t    x_q;
    coord_t    y_q;
    pixel_t    colour_q;
    len_t      len_q;
    logic      enable_q;
    logic      start_q;
    logic      frame_done;

    // no wait states and no error responses.
    assign HREADYOUT = 1'b1;
    assign HRESP     = 1'b0;

    assign addr_valid = HSEL && HTRANS[1] && HREADY;
    assign wr_done    = wr_pend && HREADY;
    assign rd_done    = rd_pend && HREADY;

    // ****************************************
    // address phase capture.
    // ****************************************
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            wr_pend <= 1'b0;
            rd_pend <= 1'b0;
            addr_q  <= '0;
        end
        else if (HREADY)
        begin
            wr_pend <= addr_valid && HWRITE;
            rd_pend <= addr_valid && !HWRITE;
            if (addr_valid)
                addr_q <= reg_addr_t'(HADDR[7:0]);
        end
    end

    // ****************************************
    // setup registers and start strobe.
    // ****************************************
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
        begin
            x_q      <= '0;
            y_q      <= '0;
            colour_q <= '0;
            len_q    <= '0;
            enable_q <= 1'b0;
            start_q  <= 1'b0;
        end
        else
        begin
            start_q <= wr_done && (addr_q == REG_START) && HWDATA[0];
            if (wr_done)
            begin
                case (addr_q)
                    REG_X      : x_q      <= HWDATA[15:0];
                    REG_Y      : y_q      <= HWDATA[15:0];
                    REG_PIXEL  : colour_q <= HWDATA[23:0];
                    REG_LEN    : len_q    <= HWDATA[15:0];
                    REG_ENABLE : enable_q <= HWDATA[0];
                    default    : ;
                endcase
            end
        end
    end

    // sticky flag, a new frame wins over a clearing read.
    always_ff @(posedge HCLK or negedge HRESETn)
    begin
        if (!HRESETn)
            frame_done <= 1'b0;
        else if (raster.frame_start)
            frame_done <= 1'b1;
        else if (rd_done && (addr_q == REG_FRAME))
            frame_done <= 1'b0;
    end

    always_comb
    begin
        HRDATA = '0;
        if (rd_pend)
        begin
            case (addr_q)
                REG_X      : HRDATA = 32'(x_q);
                REG_Y      : HRDATA = 32'(y_q);
                REG_PIXEL  : HRDATA = 32'(colour_q);
                REG_LEN    : HRDATA = 32'(len_q);
                REG_ENABLE : HRDATA = 32'(enable_q);
                REG_FRAME  : HRDATA = 32'(frame_done);
                REG_BUSY   : HRDATA = 32'(run.busy);
                default    : HRDATA = '0;
            endcase
        end
    end

    assign run.x      = x_q;
    assign run.y      = y_q;
    assign run.colour = colour_q;
    assign run.len    = len_q;
    assign run.start  = start_q;
    assign enable     = enable_q;

endmodule

// File: disp_if.sv
`timescale 1ns/100ps

// setup values and run control between the register block and the painter.
interface run_if;
    import disp_pkg::*;

    coord_t x;
    coord_t y;
    pixel_t colour;
    len_t   len;
    logic   start;
    logic   busy;

    modport ctrl
    (
        output x,
        output y,
        output colour,
        output len,
        output start,
        input  busy
    );

    modport paint
    (
        input  x,
        input  y,
        input  colour,
        input  len,
        input  start,
        output busy
    );
endinterface

// raster position and timing from the generator.
interface raster_if;
    import disp_pkg::*;

    coord_t hpos;
    coord_t vpos;
    logic   de;
    logic   hsync;
    logic   vsync;
    logic   frame_start;

    modport gen  (output hpos, output vpos, output de, output hsync, output vsync,
                  output frame_start);
    modport scan (input hpos, input vpos, input de, input hsync, input vsync);
    modport mon  (input frame_start);
endinterface

// File: disp_pkg.sv
package disp_pkg;

    // ****************************************
    // shared types.
    // ****************************************

    // 24-bit colour, red in [23:16], green in [15:8], blue in [7:0].
    typedef logic [23:0] pixel_t;

    typedef logic [15:0] coord_t;

    typedef logic [15:0] len_t;

    // byte offset inside the slave window.
    typedef logic [7:0]  reg_addr_t;

    // ****************************************
    // register map.
    // ****************************************

    localparam reg_addr_t REG_X      = 8'h00;
    localparam reg_addr_t REG_Y      = 8'h04;
    localparam reg_addr_t REG_PIXEL  = 8'h08;
    localparam reg_addr_t REG_LEN    = 8'h0C;
    localparam reg_addr_t REG_ENABLE = 8'h10;
    localparam reg_addr_t REG_START  = 8'h14;
    localparam reg_addr_t REG_FRAME  = 8'h18;
    localparam reg_addr_t REG_BUSY   = 8'h1C;

    // default raster, small enough for fast simulation.
    localparam int H_ACTIVE_DEF = 32;
    localparam int H_TOTAL_DEF  = 40;
    localparam int V_ACTIVE_DEF = 16;
    localparam int V_TOTAL_DEF  = 20;

endpackage
